//--- build.f
+incdir+testbench
logic/frame_pkg.sv
logic/checksum_check.sv
logic/frame_fifo.sv
logic/trailer_strip.sv
logic/frame_stats.sv
logic/frame_buffer.sv
testbench/tb_frame_buffer.sv

//--- Makefile
TOP = tb_frame_buffer

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert --timing -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- testbench/tb_frame_tasks.svh
// ----------------------------------------------------------------------
// stimulus and response helpers
// ----------------------------------------------------------------------

task automatic next_cycle();
  @(posedge clk);
  #1;
endtask

task automatic drive_beat(input byte_t value, input logic is_last);
  int waited;
  waited  = 0;
  s_beat  = '{data: value, last: is_last, bad: 1'($urandom)};  // checker overwrites bad.
  s_valid = 1'b1;
  while (!s_ready && waited < 100) begin
    next_cycle();
    waited++;
  end
  if (!s_ready) begin
    report_timeout("input side never raised s_ready");
  end else begin
    next_cycle();
  end
endtask

// n_beats counts the checksum byte too.
task automatic send_frame(input int n_beats, input bit corrupt, input bit dropped);
  byte_t        sum;
  byte_t        value;
  stream_beat_t want;
  int           i;
  sum = '0;
  for (i = 0; i < n_beats - 1; i++) begin
    value = byte_t'($urandom);
    sum   = byte_t'(sum + value);
    if (!corrupt && !dropped) begin
      want = '{data: value, last: (i == n_beats - 2), bad: 1'b0};
      exp_q.push_back(want);
    end
    drive_beat(value, 1'b0);
  end
  if (corrupt) begin
    value = byte_t'(sum + 8'd1 + byte_t'($urandom % 255));  // never equal to sum.
  end else begin
    value = sum;
  end
  drive_beat(value, 1'b1);
  s_valid = 1'b0;
  if (corrupt) begin
    exp_bad++;
  end else if (dropped) begin
    exp_ovf++;
  end else begin
    exp_good++;
  end
endtask

task automatic check_out_beat(input stream_beat_t got);
  stream_beat_t want;
  assert (exp_q.size() > 0) else begin
    errors++;
    $display("[ERROR] %s: output byte %0h arrived with nothing expected", test_name, got.data);
  end
  if (exp_q.size() > 0) begin
    want = exp_q.pop_front();
    check_value("data", int'(want.data), int'(got.data));
    check_value("last", int'(want.last), int'(got.last));
    check_value("bad", int'(want.bad), int'(got.bad));
  end
endtask

task automatic check_counters();
  check_value("good_count", (exp_good > 255) ? 255 : exp_good, int'(good_count));
  check_value("bad_count", (exp_bad > 255) ? 255 : exp_bad, int'(bad_count));
  check_value("overflow_count", (exp_ovf > 255) ? 255 : exp_ovf, int'(overflow_count));
endtask

task automatic wait_drain();
  int waited;
  waited = 0;
  while (exp_q.size() != 0 && waited < 2000) begin
    next_cycle();
    waited++;
  end
  if (exp_q.size() != 0) begin
    report_timeout("expected output beats never arrived");
  end
endtask

task automatic drain_and_check();
  wait_drain();
  repeat (4) next_cycle();  // last pulses reach the counters.
  check_counters();
endtask

// ----------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------

task automatic test_reset_state();
  test_name = "reset_state";
  check_value("m_valid", 0, int'(m_valid));
  check_value("s_ready", 1, int'(s_ready));
  check_counters();
endtask

task automatic test_good_frames();
  int len;
  test_name = "good_frames";
  for (len = 2; len <= 12; len++) begin
    send_frame(len, 1'b0, 1'b0);
  end
  drain_and_check();
endtask

task automatic test_bad_frames();
  test_name = "bad_frames";
  send_frame(5, 1'b0, 1'b0);
  send_frame(4, 1'b1, 1'b0);
  send_frame(6, 1'b0, 1'b0);
  send_frame(3, 1'b1, 1'b0);
  send_frame(7, 1'b1, 1'b0);
  send_frame(2, 1'b0, 1'b0);
  drain_and_check();
endtask

task automatic test_oversize_frame();
  test_name = "oversize_frame";
  send_frame(20, 1'b0, 1'b1);
  send_frame(6, 1'b0, 1'b0);
  drain_and_check();
endtask

task automatic test_backpressure();
  int n;
  int len;
  test_name  = "random_ready";
  ready_mode = READY_RANDOM;
  for (n = 0; n < 8; n++) begin
    len = 2 + int'($urandom % 11);
    send_frame(len, 1'b0, 1'b0);
    wait_drain();  // the next frame always finds the FIFO empty.
  end
  drain_and_check();

  test_name  = "ready_low";
  ready_mode = READY_LOW;
  send_frame(8, 1'b0, 1'b0);
  send_frame(8, 1'b0, 1'b0);
  send_frame(8, 1'b0, 1'b1);  // no room left for this one.
  repeat (4) next_cycle();
  check_counters();
  ready_mode = READY_HIGH;
  drain_and_check();
  repeat (20) next_cycle();  // a third frame would show up here.
endtask

task automatic test_bad_saturation();
  int n;
  test_name = "bad_saturation";
  for (n = 0; n < 260; n++) begin
    send_frame(2 + n % 3, 1'b1, 1'b0);
  end
  drain_and_check();
  check_value("saturated bad_count", 255, int'(bad_count));
endtask

//--- testbench/tb_frame_buffer.sv
`timescale 1ns/1ps

module tb_frame_buffer;
  import frame_pkg::*;

  typedef enum logic [1:0] {READY_HIGH, READY_RANDOM, READY_LOW} ready_mode_t;

  logic         clk;
  logic         rst;
  stream_beat_t s_beat;
  logic         s_valid;
  logic         s_ready;
  stream_beat_t m_beat;
  logic         m_valid;
  logic         m_ready;
  count_t       good_count;
  count_t       bad_count;
  count_t       overflow_count;

  ready_mode_t  ready_mode;
  stream_beat_t exp_q[$];  // payload beats the DUT still owes.
  string        test_name;
  int           errors;
  int           timeouts;
  int           exp_good;
  int           exp_bad;
  int           exp_ovf;

  // ----------------------------------------------------------------------
  // clock, DUT and sink
  // ----------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  frame_buffer frame_buffer_inst (
    .clk            (clk),
    .rst            (rst),
    .s_beat         (s_beat),
    .s_valid        (s_valid),
    .s_ready        (s_ready),
    .m_beat         (m_beat),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

  initial begin
    ready_mode_t mode;
    m_ready = 1'b1;
    forever begin
      @(posedge clk);
      mode = ready_mode;  // taken at the edge, before a test can move it.
      #1;
      case (mode)
        READY_HIGH:   m_ready = 1'b1;
        READY_RANDOM: m_ready = ($urandom % 4) != 0;
        default:      m_ready = 1'b0;
      endcase
    end
  end

  // both sides are stable half a cycle after the edge.
  always @(negedge clk) begin
    if (!rst && m_valid && m_ready) begin
      check_out_beat(m_beat);
    end
  end

  `include "tb_frame_tasks.svh"

  // ----------------------------------------------------------------------
  // checking and closing report
  // ----------------------------------------------------------------------

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      errors++;
      $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("[TIMEOUT] %s: %s", test_name, what);
    finish_run();
  endtask

  initial begin
    void'($urandom(32'hfae5_889e));
    rst        = 1'b1;
    s_beat     = '0;
    s_valid    = 1'b0;
    ready_mode = READY_HIGH;
    test_name  = "reset";
    errors     = 0;
    timeouts   = 0;
    exp_good   = 0;
    exp_bad    = 0;
    exp_ovf    = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_state();
    test_good_frames();
    test_bad_frames();
    test_oversize_frame();
    test_backpressure();
    test_bad_saturation();
    finish_run();
  end

endmodule

//--- logic/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  frame_pkg::stream_beat_t s_beat,
  input  logic                    s_valid,
  output logic                    s_ready,
  output frame_pkg::stream_beat_t m_beat,
  output logic                    m_valid,
  input  logic                    m_ready,
  output frame_pkg::count_t       good_count,
  output frame_pkg::count_t       bad_count,
  output frame_pkg::count_t       overflow_count
);
  import frame_pkg::*;

  stream_beat_t chk_beat;  // checker to FIFO.
  logic         chk_valid;
  logic         chk_ready;
  stream_beat_t buf_beat;  // FIFO to trailer strip.
  logic         buf_valid;
  logic         buf_ready;
  logic         good_frame;
  logic         bad_frame;
  logic         overflow;

  // ----------------------------------------------------------------------
  // input side
  // ----------------------------------------------------------------------

  checksum_check checksum_check_inst (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (chk_beat),
    .m_valid (chk_valid),
    .m_ready (chk_ready)
  );

  frame_fifo frame_fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .s_beat     (chk_beat),
    .s_valid    (chk_valid),
    .s_ready    (chk_ready),
    .m_beat     (buf_beat),
    .m_valid    (buf_valid),
    .m_ready    (buf_ready),
    .good_frame (good_frame),
    .bad_frame  (bad_frame),
    .overflow   (overflow)
  );

  // ----------------------------------------------------------------------
  // output side
  // ----------------------------------------------------------------------

  trailer_strip trailer_strip_inst (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (buf_beat),
    .s_valid (buf_valid),
    .s_ready (buf_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

  frame_stats frame_stats_inst (
    .clk            (clk),
    .rst            (rst),
    .good_frame     (good_frame),
    .bad_frame      (bad_frame),
    .overflow       (overflow),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

endmodule

//--- logic/frame_stats.sv
`timescale 1ns/1ps

module frame_stats (
  input  logic              clk,
  input  logic              rst,
  input  logic              good_frame,
  input  logic              bad_frame,
  input  logic              overflow,
  output frame_pkg::count_t good_count,
  output frame_pkg::count_t bad_count,
  output frame_pkg::count_t overflow_count
);
  import frame_pkg::*;

  // holds at all ones.
  function automatic count_t sat_inc(input count_t cnt);
    if (cnt == '1) begin
      return cnt;
    end
    return count_t'(cnt + 1'b1);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      good_count     <= '0;
      bad_count      <= '0;
      overflow_count <= '0;
    end else begin
      if (good_frame) begin
        good_count <= sat_inc(good_count);
      end
      if (bad_frame) begin
        bad_count <= sat_inc(bad_count);
      end
      if (overflow) begin
        overflow_count <= sat_inc(overflow_count);
      end
    end
  end

endmodule

//--- logic/trailer_strip.sv
`timescale 1ns/1ps

module trailer_strip (
  input  logic                    clk,
  input  logic                    rst,
  input  frame_pkg::stream_beat_t s_beat,
  input  logic                    s_valid,
  output logic                    s_ready,
  output frame_pkg::stream_beat_t m_beat,
  output logic                    m_valid,
  input  logic                    m_ready
);
  import frame_pkg::*;

  byte_t pend_data;   // held payload byte.
  logic  pend_valid;
  logic  out_free;
  logic  take;
  logic  release_pend;

  assign out_free     = !m_valid || m_ready;
  // an empty holding slot can always take a beat without releasing one.
  assign s_ready      = !pend_valid || out_free;
  assign take         = s_valid && s_ready;
  assign release_pend = take && pend_valid;

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
      m_valid    <= 1'b0;
    end else begin
      if (release_pend) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
      if (take) begin
        // checksum beat is swallowed and leaves the slot empty.
        pend_valid <= !s_beat.last;
      end
    end
  end

  // ----------------------------------------------------------------------
  // data path
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (take && !s_beat.last) begin
      pend_data <= s_beat.data;
    end
    if (release_pend) begin
      // last moves from the checksum beat onto the final payload byte.
      m_beat <= '{data: pend_data, last: s_beat.last, bad: 1'b0};
    end
  end

endmodule

//--- logic/frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  frame_pkg::stream_beat_t s_beat,
  input  logic                    s_valid,
  output logic                    s_ready,
  output frame_pkg::stream_beat_t m_beat,
  output logic                    m_valid,
  input  logic                    m_ready,
  output logic                    good_frame,
  output logic                    bad_frame,
  output logic                    overflow
);
  import frame_pkg::*;

  stream_beat_t mem [0:FIFO_DEPTH-1];

  fifo_ptr_t wr_ptr;           // committed write pointer.
  fifo_ptr_t wr_ptr_next;
  fifo_ptr_t wr_ptr_cur;       // write pointer of the frame in progress.
  fifo_ptr_t wr_ptr_cur_next;
  fifo_ptr_t wr_ptr_vis;       // committed pointer as seen by the read side.
  fifo_ptr_t rd_ptr;

  logic drop_frame;
  logic drop_next;
  logic good_next;
  logic bad_next;
  logic overflow_next;
  logic take;
  logic write;
  logic full_cur;
  logic empty;

  stream_beat_t mem_data;
  logic         mem_valid;
  logic         store_out;
  logic         read;

  assign s_ready = 1'b1;  // drops when full and never stalls.
  assign take    = s_valid && s_ready;

  assign full_cur = (wr_ptr_cur[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                    (wr_ptr_cur[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);
  assign empty    = (wr_ptr_vis == rd_ptr);

  // ----------------------------------------------------------------------
  // write side
  // ----------------------------------------------------------------------

  always_comb begin
    write           = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    drop_next       = drop_frame;
    good_next       = 1'b0;
    bad_next        = 1'b0;
    overflow_next   = 1'b0;
    if (take) begin
      if (full_cur || drop_frame) begin
        drop_next = 1'b1;  // discard the rest of this frame.
        if (s_beat.last) begin
          wr_ptr_cur_next = wr_ptr;
          drop_next       = 1'b0;
          overflow_next   = 1'b1;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_beat.last) begin
          if (s_beat.bad) begin
            wr_ptr_cur_next = wr_ptr;  // roll back.
            bad_next        = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur + 1'b1;  // commit.
            good_next   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
      good_frame <= 1'b0;
      bad_frame  <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      drop_frame <= drop_next;
      good_frame <= good_next;
      bad_frame  <= bad_next;
      overflow   <= overflow_next;
    end
  end

  // ----------------------------------------------------------------------
  // read side through a memory read register and an output register
  // ----------------------------------------------------------------------

  assign store_out = m_ready || !m_valid;
  assign read      = (store_out || !mem_valid) && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_vis <= '0;
      rd_ptr     <= '0;
      mem_valid  <= 1'b0;
      m_valid    <= 1'b0;
    end else begin
      wr_ptr_vis <= wr_ptr;
      if (store_out || !mem_valid) begin
        mem_valid <= !empty;
      end
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (store_out) begin
        m_valid <= mem_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[FIFO_ADDR_WIDTH-1:0]] <= s_beat;
    end
    if (read) begin
      mem_data <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
    end
    if (store_out) begin
      m_beat <= '{data: mem_data.data, last: mem_data.last, bad: 1'b0};
    end
  end

endmodule

//--- logic/checksum_check.sv
`timescale 1ns/1ps

module checksum_check (
  input  logic                    clk,
  input  logic                    rst,
  input  frame_pkg::stream_beat_t s_beat,
  input  logic                    s_valid,
  output logic                    s_ready,
  output frame_pkg::stream_beat_t m_beat,
  output logic                    m_valid,
  input  logic                    m_ready
);
  import frame_pkg::*;

  byte_t sum;       // running sum of the frame so far.
  logic  take;
  logic  mismatch;

  assign s_ready  = !m_valid || m_ready;  // free or draining this cycle.
  assign take     = s_valid && s_ready;
  assign mismatch = (sum != s_beat.data);

  // ----------------------------------------------------------------------
  // control and checksum accumulator
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      sum     <= '0;
    end else begin
      if (take) begin
        m_valid <= 1'b1;
        if (s_beat.last) begin
          sum <= '0;  // next frame starts clean.
        end else begin
          sum <= byte_t'(sum + s_beat.data);
        end
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (take) begin
      m_beat.data <= s_beat.data;
      m_beat.last <= s_beat.last;
      // trailer byte must equal the sum of everything before it.
      m_beat.bad  <= s_beat.last && mismatch;
    end
  end

endmodule

//--- logic/frame_pkg.sv
package frame_pkg;

  // ----------------------------------------------------------------------
  // stream types
  // ----------------------------------------------------------------------

  typedef logic [7:0] byte_t;   // one stream data byte.
  typedef logic [7:0] count_t;  // statistics counter that saturates at 255.

  typedef struct packed {
    byte_t data;
    logic  last;  // final beat of a frame.
    logic  bad;   // checksum failure on a last beat only.
  } stream_beat_t;

  // ----------------------------------------------------------------------
  // frame FIFO depth
  // ----------------------------------------------------------------------

  localparam int FIFO_ADDR_WIDTH = 4;
  localparam int FIFO_DEPTH      = 2 ** FIFO_ADDR_WIDTH;

  // pointers carry one extra wrap bit.
  typedef logic [FIFO_ADDR_WIDTH:0] fifo_ptr_t;

endpackage
